//--- common/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// word width and register count of the core
`define XLEN      32
`define REG_COUNT 32

// RV32I base opcodes, instr[6:0]
`define OP_R      7'b0110011
`define OP_IMM    7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

`endif

//--- common/riscv_pkg.sv
package riscv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] op;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  op;
    } iType;

    typedef struct packed {
        logic [6:0] immHi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo; // imm[4:0]
        logic [6:0] op;
    } sType;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immMid; // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLow; // imm[4:1]
        logic       imm11;
        logic [6:0] op;
    } bType;

    typedef struct packed {
        logic [19:0] immUpper; // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  op;
    } uType;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLow; // imm[10:1]
        logic       imm11;
        logic [7:0] immHigh; // imm[19:12]
        logic [4:0] rd;
        logic [6:0] op;
    } jType;

    // one instruction word seen through each encoding layout
    typedef union packed {
        rType r;
        iType i;
        sType s;
        bType b;
        uType u;
        jType j;
    } instrFormat;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluXor  = 4'b0100,
        aluSll  = 4'b0101,
        aluSra  = 4'b0110,
        aluSrl  = 4'b0111,
        aluSlt  = 4'b1000,
        aluSltu = 4'b1001
    } aluOp;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSel;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,
        resImm     = 2'b11
    } resultSel;

endpackage

//--- common/ctrl_if.sv
`timescale 1ns/10ps

// control bundle from the main decoder to the datapath muxes
interface ctrlIf;
    logic                 pcSrc; // take branch or jump target
    riscv_pkg::resultSel  resultSrc; // write-back source
    logic                 memWrite; // data memory write enable
    riscv_pkg::aluOp      aluControl;
    logic                 aluSrc; // b operand is the immediate
    riscv_pkg::immSel     immSrc;
    logic                 regWrite;
    logic                 aSelPc; // a operand is pc, auipc only

    modport decoder (
        output pcSrc, resultSrc, memWrite, aluControl,
        output aluSrc, immSrc, regWrite, aSelPc
    );

    modport datapath (
        input pcSrc, resultSrc, memWrite, aluControl,
        input aluSrc, immSrc, regWrite, aSelPc
    );
endinterface

//--- control/control.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module control (
    input  logic [6:0] op, // instr[6:0]
    input  logic [2:0] funct3,
    input  logic       funct7, // instr[30]
    input  logic       zero, // alu result is zero
    input  logic       negative, // a less than b under the chosen op
    ctrlIf.decoder     ctrl
);

    // ALU decoder for register and immediate arithmetic
    function automatic riscv_pkg::aluOp aluDecode(
        input logic [6:0] opCode,
        input logic [2:0] f3,
        input logic       f7
    );
        riscv_pkg::aluOp sel;
        case (f3)
            3'd0: sel = (opCode == `OP_R && f7) ? riscv_pkg::aluSub : riscv_pkg::aluAdd;
            3'd1: sel = riscv_pkg::aluSll;
            3'd2: sel = riscv_pkg::aluSlt;
            3'd3: sel = riscv_pkg::aluSltu;
            3'd4: sel = riscv_pkg::aluXor;
            3'd5: sel = f7 ? riscv_pkg::aluSra : riscv_pkg::aluSrl;
            3'd6: sel = riscv_pkg::aluOr;
            default: sel = riscv_pkg::aluAnd; // funct3 = 7
        endcase
        return sel;
    endfunction

    // compare op for branches, unsigned pair needs sltu
    function automatic riscv_pkg::aluOp branchOp(input logic [2:0] f3);
        riscv_pkg::aluOp sel;
        case (f3[2:1])
            2'b10:   sel = riscv_pkg::aluSlt; // blt, bge
            2'b11:   sel = riscv_pkg::aluSltu; // bltu, bgeu
            default: sel = riscv_pkg::aluSub; // beq, bne
        endcase
        return sel;
    endfunction

    always_comb begin
        ctrl.regWrite   = 1'b0; // defaults keep every path assigned
        ctrl.immSrc     = riscv_pkg::immI;
        ctrl.memWrite   = 1'b0;
        ctrl.resultSrc  = riscv_pkg::resAlu;
        ctrl.pcSrc      = 1'b0;
        ctrl.aluSrc     = 1'b0;
        ctrl.aluControl = riscv_pkg::aluAdd;
        ctrl.aSelPc     = 1'b0;

        case (op)
            `OP_R: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluDecode(op, funct3, funct7);
            end
            `OP_IMM: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = aluDecode(op, funct3, funct7);
            end
            `OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1; // rs1 + offset
                ctrl.resultSrc = riscv_pkg::resMem;
            end
            `OP_STORE: begin
                ctrl.immSrc   = riscv_pkg::immS;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OP_BRANCH: begin
                ctrl.immSrc     = riscv_pkg::immB;
                ctrl.aluControl = branchOp(funct3);
                case (funct3)
                    3'b000:  ctrl.pcSrc = zero; // beq
                    3'b001:  ctrl.pcSrc = ~zero; // bne
                    3'b100:  ctrl.pcSrc = negative; // blt
                    3'b101:  ctrl.pcSrc = ~negative; // bge
                    3'b110:  ctrl.pcSrc = negative; // bltu
                    3'b111:  ctrl.pcSrc = ~negative; // bgeu
                    default: ctrl.pcSrc = 1'b0;
                endcase
            end
            `OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = riscv_pkg::immJ;
                ctrl.resultSrc = riscv_pkg::resPcPlus4; // link
                ctrl.pcSrc     = 1'b1;
            end
            `OP_JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1; // target from rs1 + imm
                ctrl.resultSrc = riscv_pkg::resPcPlus4;
                ctrl.pcSrc     = 1'b1;
            end
            `OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = riscv_pkg::immU;
                ctrl.resultSrc = riscv_pkg::resImm;
            end
            `OP_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.immSrc   = riscv_pkg::immU;
                ctrl.aluSrc   = 1'b1;
                ctrl.aSelPc   = 1'b1; // pc + upper imm
            end
            default: begin
                // unsupported opcode acts as a nop
            end
        endcase
    end

endmodule

//--- source/alu.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  riscv_pkg::aluOp  aluControl,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             negative
);

    localparam int ShiftW = $clog2(`XLEN);

    logic [ShiftW-1:0] shamt;

    assign shamt = b[ShiftW-1:0]; // only the low bits count for shifts

    always_comb begin
        case (aluControl)
            riscv_pkg::aluAdd:  result = a + b;
            riscv_pkg::aluSub:  result = a - b;
            riscv_pkg::aluAnd:  result = a & b;
            riscv_pkg::aluOr:   result = a | b;
            riscv_pkg::aluXor:  result = a ^ b;
            riscv_pkg::aluSll:  result = a << shamt;
            riscv_pkg::aluSra:  result = $signed(a) >>> shamt;
            riscv_pkg::aluSrl:  result = a >> shamt;
            riscv_pkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            riscv_pkg::aluSltu: result = {{(`XLEN-1){1'b0}}, a < b};
            default:            result = '0;
        endcase
    end

    assign zero = (result == '0);

    // less-than flag, its source depends on the compare op
    always_comb begin
        case (aluControl)
            riscv_pkg::aluSlt,
            riscv_pkg::aluSltu: negative = result[0];
            default:            negative = result[`XLEN-1]; // sign of a - b
        endcase
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module reg_file (
    input  logic             clk,
    input  logic             rstN,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             we,
    input  logic [`XLEN-1:0] wd,
    output logic [`XLEN-1:0] rd1,
    output logic [`XLEN-1:0] rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wd;
        end
    end

    // combinational reads, x0 forced to zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- source/imm_extend.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module imm_extend (
    input  riscv_pkg::instrFormat instr,
    input  riscv_pkg::immSel      immSrc,
    output logic [`XLEN-1:0]      immExt
);

    always_comb begin
        case (immSrc)
            riscv_pkg::immI: immExt = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            riscv_pkg::immS: immExt = {{(`XLEN-12){instr.s.immHi[6]}},
                                       instr.s.immHi, instr.s.immLo};
            // branch offset, bit 0 always zero
            riscv_pkg::immB: immExt = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11,
                                       instr.b.immMid, instr.b.immLow, 1'b0};
            riscv_pkg::immJ: immExt = {{(`XLEN-20){instr.j.imm20}}, instr.j.immHigh,
                                       instr.j.imm11, instr.j.immLow, 1'b0};
            riscv_pkg::immU: immExt = {instr.u.immUpper, 12'b0}; // lui, auipc
            default:         immExt = '0;
        endcase
    end

endmodule

//--- source/riscv_core.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_core (
    input  logic             clk,
    input  logic             rstN,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] readData,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] writeData,
    output logic             memWrite
);

    riscv_pkg::instrFormat instrView;

    logic [`XLEN-1:0] immExt;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;
    logic             zero;
    logic             negative;
    logic             isJalr;

    ctrlIf ctrl ();

    assign instrView = instr;

    control i_control (
        .op       (instrView.r.op),
        .funct3   (instrView.r.funct3),
        .funct7   (instrView.r.funct7[5]), // instr[30]
        .zero     (zero),
        .negative (negative),
        .ctrl     (ctrl.decoder)
    );

    reg_file i_reg_file (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (instrView.r.rs1),
        .rs2  (instrView.r.rs2),
        .rd   (instrView.r.rd),
        .we   (ctrl.regWrite),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    imm_extend i_imm_extend (
        .instr  (instrView),
        .immSrc (ctrl.immSrc),
        .immExt (immExt)
    );

    assign srcA = ctrl.aSelPc ? pc : rd1; // pc only for auipc
    assign srcB = ctrl.aluSrc ? immExt : rd2;

    alu i_alu (
        .a          (srcA),
        .b          (srcB),
        .aluControl (ctrl.aluControl),
        .result     (aluResult),
        .zero       (zero),
        .negative   (negative)
    );

    // next pc
    assign pcPlus4  = pc + `XLEN'd4;
    assign isJalr   = (instrView.r.op == `OP_JALR);
    assign pcTarget = isJalr ? {aluResult[`XLEN-1:1], 1'b0} : pc + immExt;
    assign pcNext   = ctrl.pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    always_comb begin
        case (ctrl.resultSrc)
            riscv_pkg::resMem:     result = readData;
            riscv_pkg::resPcPlus4: result = pcPlus4; // link address
            riscv_pkg::resImm:     result = immExt;
            default:               result = aluResult;
        endcase
    end

    assign dataAddr  = aluResult;
    assign writeData = rd2;
    assign memWrite  = ctrl.memWrite & rstN; // no stores during reset

endmodule

//--- bench/riscv_core_asserts.sv
`timescale 1ns/10ps

module riscv_core_asserts (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] pc,
    input logic [31:0] dataAddr,
    input logic        memWrite
);

    int errorCount = 0; // summed into the final report

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned: %08h", pc);
            errorCount++;
        end

    noWriteInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
        else begin
            $error("memWrite is high while reset is active");
            errorCount++;
        end

    // stores are full words only
    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> dataAddr[1:0] == 2'b00)
        else begin
            $error("store address is not word aligned: %08h", dataAddr);
            errorCount++;
        end

endmodule

bind riscv_core riscv_core_asserts i_riscv_core_asserts (.*);

//--- bench/tb_riscv_core.sv
`timescale 1ns/10ps
`include "riscv_defines.svh"

module tb_riscv_core;

    localparam int ClkPeriod = 40;
    localparam int StimDelay = 5; // drive point after the rising edge
    localparam int MaxSteps  = 96;
    localparam logic [31:0] Nop = 32'h0000_0013; // addi x0, x0, 0

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [31:0] readData;
    logic [31:0] pc;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic        memWrite;

    // program table, indexed by pc / 4
    logic [31:0] progInstr [MaxSteps];
    logic [31:0] expNext [MaxSteps];
    logic        expWe [MaxSteps];
    logic [31:0] expAddr [MaxSteps];
    logic [31:0] expData [MaxSteps];
    string       stepName [MaxSteps];
    int          n = 0;
    int          slot = 0; // next free store address
    logic        tableReady = 1'b0;

    logic [31:0] dmem [64];
    int          stepErrors;
    int          passCount = 0;
    int          failCount = 0;

    riscv_core i_riscv_core (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // data memory model
    assign readData = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[7:2]] <= writeData;
        end
    end

    function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_R};
    endfunction

    function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] branchTo(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] upperImm(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jumpLink(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    task automatic addStep(input string name, input logic [31:0] word,
                           input logic [31:0] nextPc, input logic we,
                           input logic [31:0] addr, input logic [31:0] data);
        progInstr[n] = word;
        expNext[n]   = nextPc;
        expWe[n]     = we;
        expAddr[n]   = addr;
        expData[n]   = data;
        stepName[n]  = name;
        n++;
    endtask

    task automatic storeReg(input string name, input logic [4:0] rs2, input logic [31:0] value);
        addStep(name, storeWord(rs2, 5'd0, 12'(slot)), 32'(n * 4 + 4), 1'b1, 32'(slot), value);
        slot += 4;
    endtask

    // result lands in rd, the following sw shows it on writeData
    task automatic resultThenStore(input string name, input logic [31:0] word,
                                   input logic [31:0] value);
        addStep(name, word, 32'(n * 4 + 4), 1'b0, '0, '0);
        storeReg({"sw ", name}, word[11:7], value);
    endtask

    // taken branches skip the nop behind them
    task automatic branchPair(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        addStep(name, branchTo(f3, rs1, rs2, 13'd8), 32'(n * 4 + (taken ? 8 : 4)),
                1'b0, '0, '0);
        addStep("nop", Nop, 32'(n * 4 + 4), 1'b0, '0, '0);
    endtask

    task automatic buildProgram();
        int base;
        resultThenStore("addi x1", immOp(12'd6, 5'd0, 3'd0, 5'd1, `OP_IMM), 32'd6);
        resultThenStore("addi x2", immOp(12'hFFD, 5'd0, 3'd0, 5'd2, `OP_IMM), 32'hFFFF_FFFD);
        resultThenStore("add", regOp(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'd3);
        resultThenStore("sub", regOp(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), 32'd9);
        resultThenStore("sll", regOp(7'h00, 5'd1, 5'd2, 3'd1, 5'd3), 32'hFFFF_FF40);
        resultThenStore("slt", regOp(7'h00, 5'd1, 5'd2, 3'd2, 5'd3), 32'd1);
        resultThenStore("sltu", regOp(7'h00, 5'd1, 5'd2, 3'd3, 5'd3), 32'd0);
        resultThenStore("xor", regOp(7'h00, 5'd2, 5'd1, 3'd4, 5'd3), 32'hFFFF_FFFB);
        resultThenStore("srl", regOp(7'h00, 5'd1, 5'd2, 3'd5, 5'd3), 32'h03FF_FFFF);
        resultThenStore("sra", regOp(7'h20, 5'd1, 5'd2, 3'd5, 5'd3), 32'hFFFF_FFFF);
        resultThenStore("or", regOp(7'h00, 5'd2, 5'd1, 3'd6, 5'd3), 32'hFFFF_FFFF);
        resultThenStore("and", regOp(7'h00, 5'd2, 5'd1, 3'd7, 5'd3), 32'd4);
        resultThenStore("addi neg", immOp(12'd10, 5'd2, 3'd0, 5'd3, `OP_IMM), 32'd7);
        resultThenStore("slti", immOp(12'd1, 5'd2, 3'd2, 5'd3, `OP_IMM), 32'd1);
        resultThenStore("sltiu", immOp(12'd1, 5'd2, 3'd3, 5'd3, `OP_IMM), 32'd0);
        resultThenStore("xori", immOp(12'h0FF, 5'd1, 3'd4, 5'd3, `OP_IMM), 32'h0000_00F9);
        resultThenStore("ori", immOp(12'hFF0, 5'd1, 3'd6, 5'd3, `OP_IMM), 32'hFFFF_FFF6);
        resultThenStore("andi", immOp(12'h07F, 5'd2, 3'd7, 5'd3, `OP_IMM), 32'h0000_007D);
        resultThenStore("slli", immOp(12'h004, 5'd1, 3'd1, 5'd3, `OP_IMM), 32'h0000_0060);
        resultThenStore("srli", immOp(12'h004, 5'd2, 3'd5, 5'd3, `OP_IMM), 32'h0FFF_FFFF);
        resultThenStore("srai", immOp(12'h401, 5'd2, 3'd5, 5'd3, `OP_IMM), 32'hFFFF_FFFE);
        // load path through data memory
        addStep("sw to 0xc0", storeWord(5'd2, 5'd0, 12'h0C0), 32'(n * 4 + 4), 1'b1,
                32'h0000_00C0, 32'hFFFF_FFFD);
        addStep("lw x4", immOp(12'h0C0, 5'd0, 3'd2, 5'd4, `OP_LOAD), 32'(n * 4 + 4),
                1'b0, '0, '0);
        storeReg("sw x4", 5'd4, 32'hFFFF_FFFD);
        // x1 = 6, x2 = -3
        branchPair("beq taken", 3'd0, 5'd1, 5'd1, 1'b1);
        branchPair("beq not taken", 3'd0, 5'd1, 5'd2, 1'b0);
        branchPair("bne taken", 3'd1, 5'd1, 5'd2, 1'b1);
        branchPair("bne not taken", 3'd1, 5'd1, 5'd1, 1'b0);
        branchPair("blt taken", 3'd4, 5'd2, 5'd1, 1'b1);
        branchPair("blt not taken", 3'd4, 5'd1, 5'd2, 1'b0);
        branchPair("bge taken", 3'd5, 5'd1, 5'd2, 1'b1);
        branchPair("bge not taken", 3'd5, 5'd2, 5'd1, 1'b0);
        branchPair("bltu taken", 3'd6, 5'd1, 5'd2, 1'b1);
        branchPair("bltu not taken", 3'd6, 5'd2, 5'd1, 1'b0);
        branchPair("bgeu taken", 3'd7, 5'd2, 5'd1, 1'b1);
        branchPair("bgeu not taken", 3'd7, 5'd1, 5'd2, 1'b0);
        base = n * 4;
        addStep("jal x5", jumpLink(5'd5, 21'd8), 32'(base + 8), 1'b0, '0, '0);
        addStep("skipped", Nop, 32'(n * 4 + 4), 1'b0, '0, '0);
        storeReg("sw x5", 5'd5, 32'(base + 4));
        base = n * 4;
        // odd sum, target must drop bit 0
        addStep("addi x7", immOp(12'(base + 6), 5'd0, 3'd0, 5'd7, `OP_IMM), 32'(base + 4),
                1'b0, '0, '0);
        addStep("jalr x6", immOp(12'd7, 5'd7, 3'd0, 5'd6, `OP_JALR), 32'(base + 12),
                1'b0, '0, '0);
        addStep("skipped", Nop, 32'(n * 4 + 4), 1'b0, '0, '0);
        storeReg("sw x6", 5'd6, 32'(base + 8));
        resultThenStore("lui", upperImm(20'h12345, 5'd8, `OP_LUI), 32'h1234_5000);
        resultThenStore("auipc", upperImm(20'h80000, 5'd9, `OP_AUIPC),
                        32'(n * 4) + 32'h8000_0000);
    endtask

    task automatic checkWord(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s expected %08h got %08h", $time, sig, exp, got);
            stepErrors++;
        end
    endtask

    task automatic reportStep(input string name, input logic [31:0] stepPc);
        if (stepErrors == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("[%0t] pc %08h %s: %s", $time, stepPc, name, stepErrors == 0 ? "ok" : "FAIL");
    endtask

    // watchdog sized from the table length
    initial begin
        wait (tableReady);
        #((n * 2 + 20) * ClkPeriod);
        $display("Timeout: the program did not reach its end after %0d cycles", n * 2 + 20);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int idx;
        int assertErrors;
        logic [31:0] stepPc;
        clk   = 1'b0;
        rstN  = 1'b0;
        instr = storeWord(5'd0, 5'd0, 12'h000); // store held in reset, must stay masked
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'h5A5A_0000 | 32'(i * 4); // fill tagged with its address
        end
        buildProgram();
        tableReady = 1'b1;

        repeat (10) @(posedge clk);
        #StimDelay;
        stepErrors = 0;
        checkWord("pc", pc, 32'h0);
        checkWord("memWrite", {31'b0, memWrite}, 32'h0);
        reportStep("reset", pc);
        rstN = 1'b1;

        while (pc < 32'(n * 4)) begin
            idx        = int'(pc[31:2]);
            stepPc     = pc;
            stepErrors = 0;
            instr      = progInstr[idx];
            #(ClkPeriod / 2); // outputs settled before the edge
            checkWord("memWrite", {31'b0, memWrite}, {31'b0, expWe[idx]});
            if (expWe[idx]) begin
                checkWord("dataAddr", dataAddr, expAddr[idx]);
                checkWord("writeData", writeData, expData[idx]);
            end
            @(posedge clk);
            #StimDelay;
            checkWord("pc", pc, expNext[idx]);
            reportStep(stepName[idx], stepPc);
        end

        assertErrors = i_riscv_core.i_riscv_core_asserts.errorCount;
        $display("Summary: %0d steps passed, %0d steps failed, %0d assertion failures",
                 passCount, failCount, assertErrors);
        if (failCount == 0 && assertErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/riscv_pkg.sv
common/ctrl_if.sv
control/control.sv
source/alu.sv
source/reg_file.sv
source/imm_extend.sv
source/riscv_core.sv
bench/riscv_core_asserts.sv
bench/tb_riscv_core.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - common
    files:
      - common/riscv_pkg.sv
      - common/ctrl_if.sv
      - control/control.sv
      - source/alu.sv
      - source/reg_file.sv
      - source/imm_extend.sv
      - source/riscv_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/riscv_core_asserts.sv
      - bench/tb_riscv_core.sv
